//--- bench/frame_vectors.txt
// First word threshold, then per frame 256 pixel bytes in raster order, two rows per line,
// then the hit count and nine hit slots (tile row high nibble, column low nibble), zero padded
c8
// Frame 0, flat gray
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
00 00 00 00 00 00 00 00 00 00
// Frame 1, darker eye band in tiles (1,1) and (1,2)
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 38 38 38 38 38 38 38 38 40 40 40 40 40 40 40 40 38 38 38 38 38 38 38 38 40 40 40 40
40 40 40 40 38 38 38 38 38 38 38 38 40 40 40 40 40 40 40 40 38 38 38 38 38 38 38 38 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
01 11 00 00 00 00 00 00 00 00
// Frame 2, dark and bright horizontal bands
08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10
18 18 18 18 18 18 18 18 18 18 18 18 18 18 18 18 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10
70 70 70 70 70 70 70 70 70 70 70 70 70 70 70 70 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
90 90 90 90 90 90 90 90 90 90 90 90 90 90 90 90 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10
18 18 18 18 18 18 18 18 18 18 18 18 18 18 18 18 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10
70 70 70 70 70 70 70 70 70 70 70 70 70 70 70 70 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
90 90 90 90 90 90 90 90 90 90 90 90 90 90 90 90 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
06 00 01 02 20 21 22 00 00 00

//--- bench/tb_face_detection_ip.sv
`timescale 1ns/1ps

module tb_face_detection_ip;

  import fd_pkg::*;

  // Must match the threshold line of the vectors file
  localparam int THRESHOLD   = 200;
  localparam int FRAME_PIX   = FRAME_DIM * FRAME_DIM;
  localparam int NUM_WIN     = WIN_PER_SIDE * WIN_PER_SIDE;
  // Pixels, hit count, nine hit slots
  localparam int FRAME_WORDS = FRAME_PIX + 1 + NUM_WIN;
  localparam int VEC_WORDS   = 1 + 3 * FRAME_WORDS;
  localparam int POLL_LIMIT  = 50;

  logic              s_clk;
  logic              rst;
  logic [ADDR_W-1:0] s_address;
  logic              s_write;
  logic [DATA_W-1:0] s_writedata;
  logic              s_read;
  logic [DATA_W-1:0] s_readdata;

  logic [7:0]        vec [VEC_WORDS];
  logic [31:0]       rng_state;
  logic [7:0]        rd;

  face_detection_ip #(
    .threshold (THRESHOLD),
    .hit_depth (16)
  ) dut0
  (
    .s_clk       (s_clk),
    .rst         (rst),
    .s_address   (s_address),
    .s_write     (s_write),
    .s_writedata (s_writedata),
    .s_read      (s_read),
    .s_readdata  (s_readdata)
  );

  // 100 ns period
  always
  begin
    #50 s_clk = ~s_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (expected !== actual)
    begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // Entered and left 5 ns after a rising edge
  task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    s_address   = addr;
    s_writedata = data;
    s_write     = 1'b1;
    @(posedge s_clk);
    #5;
    s_write = 1'b0;
  endtask

  // Read register loads on the strobe edge, sampled 5 ns later
  task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    s_address = addr;
    s_read    = 1'b1;
    @(posedge s_clk);
    #5;
    s_read = 1'b0;
    data   = s_readdata;
  endtask

  // Poll status until it matches, bounded
  task automatic wait_status(input logic [DATA_W-1:0] state, input string state_name);
    int         n;
    logic [7:0] st;
    bit         seen;
    seen = 1'b0;
    for (n = 0; n < POLL_LIMIT && !seen; n++)
    begin
      host_read(ADDR_CMD, st);
      if (st == state)
      begin
        seen = 1'b1;
      end
    end
    if (!seen)
    begin
      $display("timeout while waiting for status %s, last status was %0d", state_name, st);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // Status must stay put for a whole poll window
  task automatic hold_status(input logic [DATA_W-1:0] state, input string state_name);
    int         n;
    logic [7:0] st;
    for (n = 0; n < POLL_LIMIT; n++)
    begin
      host_read(ADDR_CMD, st);
      check_value($sformatf("%s poll %0d", state_name, n), state, st);
    end
  endtask

  // Pixel bytes from the xorshift stream
  task automatic random_pixels(input int n);
    int i;
    for (i = 0; i < n; i++)
    begin
      rng_state = xorshift(rng_state);
      host_write(ADDR_PIXEL, rng_state[7:0]);
    end
  endtask

  // Open a frame, stream all pixels, wait for the scan, check the count
  task automatic load_frame(input int f);
    int         base;
    int         i;
    logic [7:0] st;
    base = 1 + f * FRAME_WORDS;
    host_write(ADDR_CMD, CMD_START_PIXEL);
    host_read(ADDR_CMD, st);
    check_value($sformatf("frame%0d receiving status", f), ST_RECEIVING, st);
    for (i = 0; i < FRAME_PIX; i++)
    begin
      host_write(ADDR_PIXEL, vec[base + i]);
    end
    wait_status(ST_FRAME_DONE, "frame done");
    host_read(ADDR_COUNT, st);
    check_value($sformatf("frame%0d hit count", f), vec[base + FRAME_PIX], st);
  endtask

  // Drain the queue in result mode and compare against the file
  task automatic read_hits(input int f);
    int         base;
    int         k;
    int         n;
    logic [7:0] st;
    base = 1 + f * FRAME_WORDS;
    n    = vec[base + FRAME_PIX];
    host_write(ADDR_CMD, CMD_START_RESULT);
    for (k = 0; k < n; k++)
    begin
      host_read(ADDR_CMD, st);
      check_value($sformatf("frame%0d sending status %0d", f, k), ST_SENDING, st);
      host_read(ADDR_HIT, st);
      check_value($sformatf("frame%0d hit %0d", f, k), vec[base + FRAME_PIX + 1 + k], st);
    end
    host_read(ADDR_CMD, st);
    check_value($sformatf("frame%0d result end status", f), ST_RESULT_END, st);
    // Empty queue reads zero
    host_read(ADDR_HIT, st);
    check_value($sformatf("frame%0d empty hit read", f), 8'h00, st);
    host_write(ADDR_CMD, CMD_STOP_RESULT);
    host_read(ADDR_CMD, st);
    check_value($sformatf("frame%0d status after result", f), ST_FRAME_DONE, st);
  endtask

  initial
  begin
    s_clk       = 1'b0;
    rst         = 1'b1;
    s_address   = '0;
    s_write     = 1'b0;
    s_writedata = '0;
    s_read      = 1'b0;
    rng_state   = 32'h4009bf38;

    $readmemh("bench/frame_vectors.txt", vec);
    if ($isunknown(vec[0]) || $isunknown(vec[VEC_WORDS - 1]))
    begin
      $display("the vectors file is missing or shorter than expected");
      $display("ERRORS FOUND");
      $fatal(1);
    end
    check_value("threshold", vec[0], 16'(THRESHOLD));

    // Five cycles of reset
    repeat (5) @(posedge s_clk);
    #5;
    rst = 1'b0;

    host_read(ADDR_CMD, rd);
    check_value("status after reset", ST_IDLE, rd);
    host_read(ADDR_PIXEL, rd);
    check_value("pixel address read", 8'h00, rd);

    // A full frame of stray pixels outside a frame, none may count
    random_pixels(FRAME_PIX);
    hold_status(ST_IDLE, "status after stray pixels");
    host_read(ADDR_COUNT, rd);
    check_value("count after stray pixels", 8'h00, rd);

    // Flat frame
    load_frame(0);
    read_hits(0);

    load_frame(1);
    read_hits(1);

    // Abort half way, then a clean frame
    host_write(ADDR_CMD, CMD_START_PIXEL);
    random_pixels(100);
    host_write(ADDR_CMD, CMD_STOP_PIXEL);
    host_read(ADDR_CMD, rd);
    check_value("status after abort", ST_IDLE, rd);
    load_frame(2);
    read_hits(2);

    // Soft reset with a hit still queued
    load_frame(1);
    host_write(ADDR_CMD, CMD_RESET);
    host_read(ADDR_CMD, rd);
    check_value("status after soft reset", ST_IDLE, rd);
    host_read(ADDR_COUNT, rd);
    check_value("count after soft reset", 8'h00, rd);

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- logic/avalon_cmd_bridge.sv
`timescale 1ns/1ps

module avalon_cmd_bridge
(
  input  logic                      s_clk,
  input  logic                      rst,
  input  logic [fd_pkg::ADDR_W-1:0] s_address,
  input  logic                      s_write,
  input  logic [fd_pkg::DATA_W-1:0] s_writedata,
  input  logic                      s_read,
  input  logic                      frame_end,
  input  logic                      scan_done,
  input  logic [fd_pkg::DATA_W-1:0] hit_data,
  input  logic [fd_pkg::DATA_W-1:0] hit_count,
  input  logic                      hit_empty,
  output logic [fd_pkg::DATA_W-1:0] s_readdata,
  output logic                      soft_rst,
  output logic                      receiving,
  output logic                      frame_abort,
  output logic                      pixel_valid,
  output logic [fd_pkg::DATA_W-1:0] pixel,
  output logic                      result_mode,
  output logic                      hit_pop
);

  import fd_pkg::*;

  logic              cmd_wr;
  logic              start_pixel;
  logic              start_result;
  logic              stop_result;
  logic [DATA_W-1:0] status;
  logic [DATA_W-1:0] rd_next;

  // Command decode, one write per strobe
  assign cmd_wr       = s_write && (s_address == ADDR_CMD);
  assign soft_rst     = cmd_wr && (s_writedata == CMD_RESET);
  assign start_pixel  = cmd_wr && (s_writedata == CMD_START_PIXEL);
  assign frame_abort  = cmd_wr && (s_writedata == CMD_STOP_PIXEL);
  assign start_result = cmd_wr && (s_writedata == CMD_START_RESULT);
  assign stop_result  = cmd_wr && (s_writedata == CMD_STOP_RESULT);

  // Pixel bytes pass only while a frame is open
  assign pixel_valid = s_write && (s_address == ADDR_PIXEL) && receiving;
  assign pixel       = s_writedata;

  // Pop lines up with the read register capturing the head entry
  assign hit_pop = s_read && (s_address == ADDR_HIT) && !hit_empty;

  // Frame reception flag
  always_ff @(posedge s_clk)
  begin
    if (rst || soft_rst)
    begin
      receiving <= 1'b0;
    end
    else if (start_pixel)
    begin
      receiving <= 1'b1;
    end
    else if (frame_abort || frame_end)
    begin
      receiving <= 1'b0;
    end
  end

  // Result readout flag
  always_ff @(posedge s_clk)
  begin
    if (rst || soft_rst)
    begin
      result_mode <= 1'b0;
    end
    else if (start_result)
    begin
      result_mode <= 1'b1;
    end
    else if (stop_result)
    begin
      result_mode <= 1'b0;
    end
  end

  // Status priority, result mode first
  always_comb
  begin
    if (result_mode)
    begin
      status = hit_empty ? ST_RESULT_END : ST_SENDING;
    end
    else if (receiving)
    begin
      status = ST_RECEIVING;
    end
    else if (scan_done)
    begin
      status = ST_FRAME_DONE;
    end
    else
    begin
      status = ST_IDLE;
    end
  end

  // Read source by address
  always_comb
  begin
    case (s_address)
      ADDR_CMD:   rd_next = status;
      // Empty queue reads as zero
      ADDR_HIT:   rd_next = hit_empty ? '0 : hit_data;
      ADDR_COUNT: rd_next = hit_count;
      default:    rd_next = '0;
    endcase
  end

  // Read data valid the cycle after the strobe, held until the next read
  always_ff @(posedge s_clk)
  begin
    if (rst)
    begin
      s_readdata <= '0;
    end
    else if (s_read)
    begin
      s_readdata <= rd_next;
    end
  end

endmodule

//--- logic/face_detection_ip.sv
`timescale 1ns/1ps

module face_detection_ip
#(
  parameter logic signed [fd_pkg::SCORE_W-1:0] threshold = 200,
  parameter int                                hit_depth = 16
)
(
  input  logic                      s_clk,
  input  logic                      rst,
  input  logic [fd_pkg::ADDR_W-1:0] s_address,
  input  logic                      s_write,
  input  logic [fd_pkg::DATA_W-1:0] s_writedata,
  input  logic                      s_read,
  output logic [fd_pkg::DATA_W-1:0] s_readdata
);

  import fd_pkg::*;

  // Bridge to engine
  logic                            soft_rst;
  logic                            receiving;
  logic                            frame_abort;
  logic                            pixel_valid;
  logic [DATA_W-1:0]               pixel;
  logic                            hit_pop;

  // Accumulator to scanner
  logic                            frame_end;
  logic [NUM_TILES*TILE_SUM_W-1:0] tile_sums;

  // Scanner to queue and bridge
  logic                            hit_valid;
  logic [DATA_W-1:0]               hit_coord;
  logic                            scan_done;

  // Queue to bridge
  logic [DATA_W-1:0]               hit_data;
  logic [DATA_W-1:0]               hit_count;
  logic                            hit_empty;

  // Host port, command decode and status
  avalon_cmd_bridge u_bridge
  (
    .s_clk       (s_clk),
    .rst         (rst),
    .s_address   (s_address),
    .s_write     (s_write),
    .s_writedata (s_writedata),
    .s_read      (s_read),
    .frame_end   (frame_end),
    .scan_done   (scan_done),
    .hit_data    (hit_data),
    .hit_count   (hit_count),
    .hit_empty   (hit_empty),
    .s_readdata  (s_readdata),
    .soft_rst    (soft_rst),
    .receiving   (receiving),
    .frame_abort (frame_abort),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    // Result mode only steers the status inside the bridge
    .result_mode (),
    .hit_pop     (hit_pop)
  );

  tile_accumulator u_accum
  (
    .s_clk       (s_clk),
    .rst         (rst),
    .soft_rst    (soft_rst),
    .frame_abort (frame_abort),
    .receiving   (receiving),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .frame_end   (frame_end),
    .tile_sums   (tile_sums)
  );

  haar_window_scan #(
    .threshold (threshold)
  ) u_scan
  (
    .s_clk     (s_clk),
    .rst       (rst),
    .soft_rst  (soft_rst),
    .frame_end (frame_end),
    .receiving (receiving),
    .tile_sums (tile_sums),
    .hit_valid (hit_valid),
    .hit_coord (hit_coord),
    .scan_done (scan_done)
  );

  hit_fifo #(
    .hit_depth (hit_depth)
  ) u_hits
  (
    .s_clk     (s_clk),
    .rst       (rst),
    .soft_rst  (soft_rst),
    .receiving (receiving),
    .hit_valid (hit_valid),
    .hit_coord (hit_coord),
    .hit_pop   (hit_pop),
    .hit_data  (hit_data),
    .hit_count (hit_count),
    .hit_empty (hit_empty)
  );

endmodule

//--- logic/fd_pkg.sv
package fd_pkg;

  // Host bus geometry
  localparam int DATA_W = 8;
  localparam int ADDR_W = 2;

  // Frame geometry, pixels per side
  localparam int FRAME_DIM = 16;
  localparam int TILE_DIM = 4;
  localparam int TILES_PER_SIDE = FRAME_DIM / TILE_DIM;
  localparam int NUM_TILES = TILES_PER_SIDE * TILES_PER_SIDE;
  // 2 by 2 tile windows at a stride of one tile
  localparam int WIN_PER_SIDE = TILES_PER_SIDE - 1;
  // Flat tile index, row bits above column bits
  localparam int TILE_IDX_W = $clog2(NUM_TILES);

  // One tile holds at most 16 * 255 = 4080
  localparam int TILE_SUM_W = 12;
  // Signed difference of two tile pairs
  localparam int SCORE_W = 14;

  // Command bytes written at ADDR_CMD
  localparam logic [DATA_W-1:0] CMD_RESET        = 8'd0;
  localparam logic [DATA_W-1:0] CMD_START_PIXEL  = 8'd1;
  localparam logic [DATA_W-1:0] CMD_STOP_PIXEL   = 8'd2;
  localparam logic [DATA_W-1:0] CMD_START_RESULT = 8'd3;
  localparam logic [DATA_W-1:0] CMD_STOP_RESULT  = 8'd4;

  // Status bytes read back at ADDR_CMD
  localparam logic [DATA_W-1:0] ST_IDLE       = 8'd0;
  localparam logic [DATA_W-1:0] ST_RECEIVING  = 8'd11;
  localparam logic [DATA_W-1:0] ST_FRAME_DONE = 8'd12;
  localparam logic [DATA_W-1:0] ST_SENDING    = 8'd13;
  localparam logic [DATA_W-1:0] ST_RESULT_END = 8'd14;

  // Register map
  localparam logic [ADDR_W-1:0] ADDR_CMD   = 2'd0;
  // Write only
  localparam logic [ADDR_W-1:0] ADDR_PIXEL = 2'd1;
  // Read pops one hit byte
  localparam logic [ADDR_W-1:0] ADDR_HIT   = 2'd2;
  // Read gives the queued hit count
  localparam logic [ADDR_W-1:0] ADDR_COUNT = 2'd3;

endpackage

//--- logic/haar_window_scan.sv
`timescale 1ns/1ps

module haar_window_scan
#(
  parameter logic signed [fd_pkg::SCORE_W-1:0] threshold = 200
)
(
  input  logic                                             s_clk,
  input  logic                                             rst,
  input  logic                                             soft_rst,
  input  logic                                             frame_end,
  input  logic                                             receiving,
  input  logic [fd_pkg::NUM_TILES*fd_pkg::TILE_SUM_W-1:0]  tile_sums,
  output logic                                             hit_valid,
  output logic [fd_pkg::DATA_W-1:0]                        hit_coord,
  output logic                                             scan_done
);

  import fd_pkg::*;

  // Window position shares the tile position width
  localparam int WPOS_W = $clog2(TILES_PER_SIDE);
  localparam int PAD_W  = DATA_W / 2 - WPOS_W;

  logic                      active_q;
  logic [WPOS_W-1:0]         win_row_q;
  logic [WPOS_W-1:0]         win_col_q;
  logic [WPOS_W-1:0]         cur_row;
  logic [WPOS_W-1:0]         cur_col;
  logic                      scanning;
  logic                      last_col;
  logic                      last_win;
  logic [TILE_SUM_W-1:0]     tile [NUM_TILES];
  logic [TILE_IDX_W-1:0]     ul_idx;
  logic [SCORE_W-2:0]        upper_sum;
  logic [SCORE_W-2:0]        lower_sum;
  logic signed [SCORE_W-1:0] score;

  always_comb
  begin
    for (int i = 0; i < NUM_TILES; i++)
    begin
      tile[i] = tile_sums[i*TILE_SUM_W +: TILE_SUM_W];
    end
  end

  // Window (0,0) is tested in the frame_end cycle itself
  assign scanning = frame_end || active_q;
  assign cur_row  = frame_end ? '0 : win_row_q;
  assign cur_col  = frame_end ? '0 : win_col_q;
  assign last_col = (cur_col == WPOS_W'(WIN_PER_SIDE - 1));
  assign last_win = last_col && (cur_row == WPOS_W'(WIN_PER_SIDE - 1));

  // Top left tile of the window
  assign ul_idx = {cur_row, cur_col};

  // Eye band on top, cheeks below
  assign upper_sum = {1'b0, tile[ul_idx]} + {1'b0, tile[ul_idx + 1'b1]};
  assign lower_sum = {1'b0, tile[ul_idx + TILE_IDX_W'(TILES_PER_SIDE)]}
                   + {1'b0, tile[ul_idx + TILE_IDX_W'(TILES_PER_SIDE + 1)]};
  assign score = $signed({1'b0, lower_sum}) - $signed({1'b0, upper_sum});

  // Hit goes straight to the queue in the cycle it is found
  assign hit_valid = scanning && (score > threshold);
  // Row in high nibble, column in low nibble
  assign hit_coord = {{PAD_W{1'b0}}, cur_row, {PAD_W{1'b0}}, cur_col};

  // Window stepper
  always_ff @(posedge s_clk)
  begin
    if (rst || soft_rst)
    begin
      active_q  <= 1'b0;
      win_row_q <= '0;
      win_col_q <= '0;
      scan_done <= 1'b0;
    end
    else
    begin
      // Done flag drops once a new frame is open
      if (receiving)
      begin
        scan_done <= 1'b0;
      end
      if (scanning)
      begin
        if (last_win)
        begin
          active_q  <= 1'b0;
          win_row_q <= '0;
          win_col_q <= '0;
          scan_done <= 1'b1;
        end
        else if (last_col)
        begin
          active_q  <= 1'b1;
          win_row_q <= cur_row + 1'b1;
          win_col_q <= '0;
        end
        else
        begin
          active_q  <= 1'b1;
          win_row_q <= cur_row;
          win_col_q <= cur_col + 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/hit_fifo.sv
`timescale 1ns/1ps

module hit_fifo
#(
  parameter int hit_depth = 16
)
(
  input  logic                      s_clk,
  input  logic                      rst,
  input  logic                      soft_rst,
  input  logic                      receiving,
  input  logic                      hit_valid,
  input  logic [fd_pkg::DATA_W-1:0] hit_coord,
  input  logic                      hit_pop,
  output logic [fd_pkg::DATA_W-1:0] hit_data,
  output logic [fd_pkg::DATA_W-1:0] hit_count,
  output logic                      hit_empty
);

  import fd_pkg::*;

  // Power of two depth lets the pointers wrap on their own
  localparam int PTR_W = $clog2(hit_depth);
  localparam int CNT_W = $clog2(hit_depth + 1);

  logic [DATA_W-1:0] mem [hit_depth];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              receiving_q;
  logic              flush;
  logic              push_ok;
  logic              pop_ok;

  always_ff @(posedge s_clk)
  begin
    if (rst)
    begin
      receiving_q <= 1'b0;
    end
    else
    begin
      receiving_q <= receiving;
    end
  end

  // Old hits go away when the next frame opens
  assign flush   = soft_rst || (receiving && !receiving_q);
  assign pop_ok  = hit_pop && !hit_empty;
  // A full queue still takes a push when a pop frees a slot
  assign push_ok = hit_valid && ((count != CNT_W'(hit_depth)) || pop_ok);

  always_ff @(posedge s_clk)
  begin
    if (rst || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_ok)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop together leave the count alone
      if (push_ok && !pop_ok)
      begin
        count <= count + 1'b1;
      end
      else if (pop_ok && !push_ok)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge s_clk)
  begin
    if (push_ok)
    begin
      mem[wr_ptr] <= hit_coord;
    end
  end

  assign hit_data  = mem[rd_ptr];
  assign hit_empty = (count == '0);
  assign hit_count = {{(DATA_W - CNT_W){1'b0}}, count};

endmodule

//--- logic/tile_accumulator.sv
`timescale 1ns/1ps

module tile_accumulator
(
  input  logic                                             s_clk,
  input  logic                                             rst,
  input  logic                                             soft_rst,
  input  logic                                             frame_abort,
  input  logic                                             receiving,
  input  logic                                             pixel_valid,
  input  logic [fd_pkg::DATA_W-1:0]                        pixel,
  output logic                                             frame_end,
  output logic [fd_pkg::NUM_TILES*fd_pkg::TILE_SUM_W-1:0]  tile_sums
);

  import fd_pkg::*;

  // Pixel position and tile position widths
  localparam int POS_W  = $clog2(FRAME_DIM);
  localparam int TPOS_W = $clog2(TILES_PER_SIDE);

  logic                  receiving_q;
  logic                  frame_open;
  logic                  wipe;
  logic [POS_W-1:0]      row_q;
  logic [POS_W-1:0]      col_q;
  logic [POS_W-1:0]      row_base;
  logic [POS_W-1:0]      col_base;
  logic                  full_q;
  logic                  full_base;
  logic                  accept;
  logic                  last_col;
  logic                  last_row;
  logic [TILE_IDX_W-1:0] tile_idx;
  logic [TILE_SUM_W-1:0] sum_q [NUM_TILES];
  logic [TILE_SUM_W-1:0] sum_base;

  // New frame on the rising edge of receiving
  always_ff @(posedge s_clk)
  begin
    if (rst)
    begin
      receiving_q <= 1'b0;
    end
    else
    begin
      receiving_q <= receiving;
    end
  end

  assign frame_open = receiving && !receiving_q;
  assign wipe       = rst || soft_rst || frame_abort;

  // First pixel may land in the opening cycle, so count from a cleared base
  assign row_base  = frame_open ? '0 : row_q;
  assign col_base  = frame_open ? '0 : col_q;
  assign full_base = frame_open ? 1'b0 : full_q;
  assign accept    = pixel_valid && !full_base && !wipe;
  assign last_col  = (col_base == POS_W'(FRAME_DIM - 1));
  assign last_row  = (row_base == POS_W'(FRAME_DIM - 1));

  // Tile picked by the upper bits of row and column
  assign tile_idx = {row_base[POS_W-1 -: TPOS_W], col_base[POS_W-1 -: TPOS_W]};
  assign sum_base = frame_open ? '0 : sum_q[tile_idx];

  // Raster counters and end of frame pulse
  always_ff @(posedge s_clk)
  begin
    if (wipe)
    begin
      row_q     <= '0;
      col_q     <= '0;
      full_q    <= 1'b0;
      frame_end <= 1'b0;
    end
    else
    begin
      frame_end <= 1'b0;
      if (frame_open)
      begin
        row_q  <= '0;
        col_q  <= '0;
        full_q <= 1'b0;
      end
      if (accept)
      begin
        col_q <= col_base + 1'b1;
        if (last_col)
        begin
          row_q <= row_base + 1'b1;
          // Pixel 256 closes the frame, later writes are dropped
          if (last_row)
          begin
            full_q    <= 1'b1;
            frame_end <= 1'b1;
          end
        end
      end
    end
  end

  // Tile sums, the accepted pixel overrides the clear
  always_ff @(posedge s_clk)
  begin
    if (wipe || frame_open)
    begin
      for (int i = 0; i < NUM_TILES; i++)
      begin
        sum_q[i] <= '0;
      end
    end
    if (accept)
    begin
      sum_q[tile_idx] <= sum_base + TILE_SUM_W'(pixel);
    end
  end

  // Flatten, tile 0 in the low bits
  always_comb
  begin
    for (int i = 0; i < NUM_TILES; i++)
    begin
      tile_sums[i*TILE_SUM_W +: TILE_SUM_W] = sum_q[i];
    end
  end

endmodule

//--- project.f
logic/fd_pkg.sv
logic/avalon_cmd_bridge.sv
logic/tile_accumulator.sv
logic/haar_window_scan.sv
logic/hit_fifo.sv
logic/face_detection_ip.sv
bench/tb_face_detection_ip.sv
